// ==== socket.f ====
+incdir+include
src/socket_pkg.sv
src/l1_cache.sv
src/mem_arb.sv
src/socket_core.sv
src/socket.sv
tb/socket_mem_model.sv
tb/socket_tb.sv

// ==== tb/socket_tb.sv ====
/*
 * Socket testbench
 * Directed tests of launch, load/add/store programs, write-through
 * hits, back-pressure and relaunch, checked against memory contents
 */
`timescale 1ns/1ps
`default_nettype none
`include "socket_cfg.svh"

module socket_tb;

    logic                 clk;
    logic                 rst_n;
    logic                 dcr_valid;
    socket_pkg::dcr_req_t dcr_req;
    logic                 bp_en;
    logic                 mem_req_valid;
    socket_pkg::mem_req_t mem_req;
    logic                 mem_req_ready;
    logic                 mem_rsp_valid;
    socket_pkg::mem_rsp_t mem_rsp;
    logic                 busy;
    int                   errors;
    int                   tests_bad;

    socket dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .dcr_valid     (dcr_valid),
        .dcr_req       (dcr_req),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .busy          (busy)
    );

    socket_mem_model mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bp_en     (bp_en),
        .req_valid (mem_req_valid),
        .req       (mem_req),
        .req_ready (mem_req_ready),
        .rsp_valid (mem_rsp_valid),
        .rsp       (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] make_instr(input socket_pkg::opcode_t op,
                                               input logic [15:0] field);
        make_instr = {op, 12'h000, field};
    endfunction

    function automatic logic [31:0] sign_ext(input logic [15:0] v);
        sign_ext = {{16{v[15]}}, v};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic dcr_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        dcr_valid    <= 1'b1;
        dcr_req.addr <= addr;
        dcr_req.data <= data;
        @(posedge clk);
        dcr_valid    <= 1'b0;
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        while (busy !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b1) begin
            $display("Timeout: busy never rose during %s", what);
            errors++;
        end
        n = 0;
        while (busy !== 1'b0 && n < 5000) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("Timeout: busy stayed high during %s", what);
            errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name, input int start_errs);
        if (errors == start_errs) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - start_errs);
            tests_bad++;
        end
    endtask

    ////////////////////
    // Tests

    // LOAD src, ADD k, STORE dst, HALT for every core in the mask
    task automatic run_simple(input logic [15:0] base, input logic [1:0] mask);
        logic [15:0] prog;
        logic [15:0] src;
        logic [15:0] k;
        logic [31:0] init;
        logic [31:0] exp;
        for (int i = 0; i < `SOCKET_SIZE; i++) begin
            prog = base + 16'(16 * i);
            src  = base + 16'h0040 + 16'(4 * i);
            k    = (i == 0) ? 16'h0123 : 16'hfff0;
            mem_i.mem[prog]       = make_instr(socket_pkg::OP_LOAD, src);
            mem_i.mem[prog + 1]   = make_instr(socket_pkg::OP_ADD, k);
            mem_i.mem[prog + 2]   = make_instr(socket_pkg::OP_STORE, src + 16'd1);
            mem_i.mem[prog + 3]   = make_instr(socket_pkg::OP_HALT, 16'h0000);
            mem_i.mem[src]        = 32'h1000_0000 + base + i;
            mem_i.mem[src + 1]    = '0;
            mem_i.wr_count[src + 1] = 0;
            if (mask[i]) begin
                dcr_write(8'(`DCR_START_PC_BASE + i), {16'h0000, prog});
            end
        end
        dcr_write(`DCR_LAUNCH, {30'h0, mask});
        wait_done("program run");
        for (int i = 0; i < `SOCKET_SIZE; i++) begin
            src  = base + 16'h0040 + 16'(4 * i);
            k    = (i == 0) ? 16'h0123 : 16'hfff0;
            init = 32'h1000_0000 + base + i;
            exp  = init + sign_ext(k);
            if (mask[i] && mem_i.mem[src + 1] !== exp) begin
                report_mismatch($sformatf("core %0d result at %h is %h, expected %h",
                                          i, src + 1, mem_i.mem[src + 1], exp));
            end
            if (mask[i] && mem_i.wr_count[src + 1] != 1) begin
                report_mismatch($sformatf("core %0d store at %h written %0d times",
                                          i, src + 1, mem_i.wr_count[src + 1]));
            end
        end
    endtask

    task automatic idle_after_reset();
        int start_errs;
        start_errs = errors;
        repeat (20) begin
            @(negedge clk);
            if (busy !== 1'b0 || mem_req_valid !== 1'b0) begin
                report_mismatch($sformatf("busy %b mem_req_valid %b while idle",
                                          busy, mem_req_valid));
            end
        end
        finish_test(1, "idle after reset", start_errs);
    endtask

    task automatic single_core_run();
        int start_errs;
        start_errs = errors;
        run_simple(16'h0100, 2'b01);
        finish_test(2, "single core", start_errs);
    endtask

    task automatic two_core_run();
        int start_errs;
        start_errs = errors;
        run_simple(16'h0200, 2'b11);
        finish_test(3, "two cores", start_errs);
    endtask

    // Second load of a must hit the line updated by the store
    task automatic write_through_hit();
        int start_errs;
        logic [31:0] exp;
        start_errs = errors;
        mem_i.mem[16'h0300]      = make_instr(socket_pkg::OP_LOAD, 16'h0340);
        mem_i.mem[16'h0301]      = make_instr(socket_pkg::OP_ADD, 16'h0055);
        mem_i.mem[16'h0302]      = make_instr(socket_pkg::OP_STORE, 16'h0340);
        mem_i.mem[16'h0303]      = make_instr(socket_pkg::OP_LOAD, 16'h0340);
        mem_i.mem[16'h0304]      = make_instr(socket_pkg::OP_STORE, 16'h0342);
        mem_i.mem[16'h0305]      = make_instr(socket_pkg::OP_HALT, 16'h0000);
        mem_i.mem[16'h0340]      = 32'h0abc_0000;
        mem_i.mem[16'h0342]      = '0;
        mem_i.rd_count[16'h0340] = 0;
        exp = 32'h0abc_0055;
        dcr_write(`DCR_START_PC_BASE, 32'h0000_0300);
        dcr_write(`DCR_LAUNCH, 32'h1);
        wait_done("write-through test");
        if (mem_i.mem[16'h0340] !== exp) begin
            report_mismatch($sformatf("stored value at 0340 is %h, expected %h",
                                      mem_i.mem[16'h0340], exp));
        end
        if (mem_i.mem[16'h0342] !== exp) begin
            report_mismatch($sformatf("reload result %h, expected %h",
                                      mem_i.mem[16'h0342], exp));
        end
        if (mem_i.rd_count[16'h0340] != 1) begin
            report_mismatch($sformatf("address 0340 read %0d times, expected 1",
                                      mem_i.rd_count[16'h0340]));
        end
        finish_test(4, "write-through hit", start_errs);
    endtask

    task automatic back_pressure_runs();
        int start_errs;
        start_errs = errors;
        @(posedge clk);
        bp_en <= 1'b1;
        run_simple(16'h0400, 2'b01);
        run_simple(16'h0500, 2'b11);
        @(posedge clk);
        bp_en <= 1'b0;
        finish_test(5, "back-pressure", start_errs);
    endtask

    task automatic relaunch_one_core();
        int start_errs;
        logic [31:0] other;
        int other_writes;
        start_errs   = errors;
        other        = mem_i.mem[16'h0541];
        other_writes = mem_i.wr_count[16'h0541];
        run_simple(16'h0600, 2'b10);
        if (mem_i.mem[16'h0541] !== other) begin
            report_mismatch($sformatf("core 0 area changed to %h, was %h",
                                      mem_i.mem[16'h0541], other));
        end
        if (mem_i.wr_count[16'h0541] != other_writes) begin
            report_mismatch($sformatf("core 0 area written %0d times, expected %0d",
                                      mem_i.wr_count[16'h0541], other_writes));
        end
        finish_test(6, "relaunch", start_errs);
    endtask

    ////////////////////
    // Main sequence

    initial begin
        rst_n     = 1'b0;
        dcr_valid = 1'b0;
        dcr_req   = '0;
        bp_en     = 1'b0;
        errors    = 0;
        tests_bad = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        idle_after_reset();
        single_core_run();
        two_core_run();
        write_through_hit();
        back_pressure_runs();
        relaunch_one_core();

        $display("tests: 6, tests with errors: %0d, errors: %0d", tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/socket_mem_model.sv ====
/*
 * Memory model for the socket memory port
 * Word array with per-address read and write counters,
 * optional back-pressure from a Galois LFSR
 */
`timescale 1ns/1ps
`default_nettype none
`include "socket_cfg.svh"

module socket_mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 bp_en,
    input  logic                 req_valid,
    input  socket_pkg::mem_req_t req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output socket_pkg::mem_rsp_t rsp
);

    logic [`DATA_WIDTH-1:0] mem      [0:(1 << `ADDR_WIDTH) - 1];
    int                     rd_count [0:(1 << `ADDR_WIDTH) - 1];
    int                     wr_count [0:(1 << `ADDR_WIDTH) - 1];
    logic [15:0]            lfsr;

    // Right-shift Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // Idle port levels before the first clock edge
    initial begin
        req_ready <= 1'b1;
        rsp_valid <= 1'b0;
        rsp       <= '0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            lfsr      <= 16'd53726;
            req_ready <= 1'b1;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            if (bp_en) begin
                // One LFSR step per ready bit
                lfsr      <= lfsr_next(lfsr);
                req_ready <= lfsr[0];
            end else begin
                req_ready <= 1'b1;
            end
            if (req_valid && req_ready) begin
                if (req.rw) begin
                    mem[req.addr]      <= req.data;
                    wr_count[req.addr] <= wr_count[req.addr] + 1;
                end else begin
                    // Read data returns the next cycle
                    rsp_valid          <= 1'b1;
                    rsp.data           <= mem[req.addr];
                    rsp.tag            <= req.tag;
                    rd_count[req.addr] <= rd_count[req.addr] + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/socket.sv ====
/*
 * Socket top level
 * Cores sharing an icache and a dcache behind one memory port,
 * buffered DCR fan-out and a registered busy level
 */
`timescale 1ns/1ps
`default_nettype none
`include "socket_cfg.svh"

module socket (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dcr_valid,
    input  socket_pkg::dcr_req_t dcr_req,
    output logic                 mem_req_valid,
    output socket_pkg::mem_req_t mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  socket_pkg::mem_rsp_t mem_rsp,
    output logic                 busy
);

    logic                    dcr_valid_q;
    socket_pkg::dcr_req_t    dcr_req_q;
    logic [`SOCKET_SIZE-1:0] core_busy;

    logic [`SOCKET_SIZE-1:0] ic_req_valid, ic_req_ready, ic_rsp_valid;
    logic [`SOCKET_SIZE-1:0] dc_req_valid, dc_req_ready, dc_rsp_valid;
    socket_pkg::mem_req_t    ic_req [`SOCKET_SIZE];
    socket_pkg::mem_req_t    dc_req [`SOCKET_SIZE];
    socket_pkg::mem_rsp_t    ic_rsp, dc_rsp;

    logic                    icm_req_valid, icm_req_ready, icm_rsp_valid;
    logic                    dcm_req_valid, dcm_req_ready, dcm_rsp_valid;
    socket_pkg::mem_req_t    icm_req, dcm_req;
    socket_pkg::mem_rsp_t    icm_rsp, dcm_rsp;

    ////////////////////
    // DCR buffer and busy

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dcr_valid_q <= 1'b0;
            busy        <= 1'b0;
        end else begin
            dcr_valid_q <= dcr_valid;
            busy        <= |core_busy;
        end
    end

    always_ff @(posedge clk) begin
        dcr_req_q <= dcr_req;
    end

    ////////////////////
    // Cores

    for (genvar i = 0; i < `SOCKET_SIZE; i++) begin : g_cores
        socket_core #(
            .CORE_ID (i)
        ) core_i (
            .clk              (clk),
            .rst_n            (rst_n),
            .dcr_valid        (dcr_valid_q),
            .dcr_req          (dcr_req_q),
            .icache_req_valid (ic_req_valid[i]),
            .icache_req       (ic_req[i]),
            .icache_req_ready (ic_req_ready[i]),
            .icache_rsp_valid (ic_rsp_valid[i]),
            .icache_rsp       (ic_rsp),
            .dcache_req_valid (dc_req_valid[i]),
            .dcache_req       (dc_req[i]),
            .dcache_req_ready (dc_req_ready[i]),
            .dcache_rsp_valid (dc_rsp_valid[i]),
            .dcache_rsp       (dc_rsp),
            .busy             (core_busy[i])
        );
    end

    ////////////////////
    // Caches and memory arbiter

    l1_cache #(
        .WRITE_ENABLE (1'b0)
    ) icache_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (ic_req_valid),
        .core_req       (ic_req),
        .core_req_ready (ic_req_ready),
        .core_rsp_valid (ic_rsp_valid),
        .core_rsp       (ic_rsp),
        .mem_req_valid  (icm_req_valid),
        .mem_req        (icm_req),
        .mem_req_ready  (icm_req_ready),
        .mem_rsp_valid  (icm_rsp_valid),
        .mem_rsp        (icm_rsp)
    );

    l1_cache #(
        .WRITE_ENABLE (1'b1)
    ) dcache_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (dc_req_valid),
        .core_req       (dc_req),
        .core_req_ready (dc_req_ready),
        .core_rsp_valid (dc_rsp_valid),
        .core_rsp       (dc_rsp),
        .mem_req_valid  (dcm_req_valid),
        .mem_req        (dcm_req),
        .mem_req_ready  (dcm_req_ready),
        .mem_rsp_valid  (dcm_rsp_valid),
        .mem_rsp        (dcm_rsp)
    );

    mem_arb mem_arb_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .icache_req_valid (icm_req_valid),
        .icache_req       (icm_req),
        .icache_req_ready (icm_req_ready),
        .dcache_req_valid (dcm_req_valid),
        .dcache_req       (dcm_req),
        .dcache_req_ready (dcm_req_ready),
        .mem_req_valid    (mem_req_valid),
        .mem_req          (mem_req),
        .mem_req_ready    (mem_req_ready),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp          (mem_rsp),
        .icache_rsp_valid (icm_rsp_valid),
        .icache_rsp       (icm_rsp),
        .dcache_rsp_valid (dcm_rsp_valid),
        .dcache_rsp       (dcm_rsp)
    );

endmodule

`default_nettype wire

// ==== src/socket_core.sv ====
/*
 * Accumulator core
 * Fetch, decode and execute of LOAD/ADD/STORE/HALT through the L1 ports,
 * started through DCR writes
 */
`timescale 1ns/1ps
`default_nettype none
`include "socket_cfg.svh"

module socket_core #(
    parameter int CORE_ID = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dcr_valid,
    input  socket_pkg::dcr_req_t dcr_req,
    output logic                 icache_req_valid,
    output socket_pkg::mem_req_t icache_req,
    input  logic                 icache_req_ready,
    input  logic                 icache_rsp_valid,
    input  socket_pkg::mem_rsp_t icache_rsp,
    output logic                 dcache_req_valid,
    output socket_pkg::mem_req_t dcache_req,
    input  logic                 dcache_req_ready,
    input  logic                 dcache_rsp_valid,
    input  socket_pkg::mem_rsp_t dcache_rsp,
    output logic                 busy
);

    localparam int PC_REG = `DCR_START_PC_BASE + CORE_ID;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_IWAIT, ST_EXEC, ST_MEM, ST_DWAIT
    } state_e;

    state_e                 state;
    logic [`ADDR_WIDTH-1:0] start_pc;
    logic [`ADDR_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] acc;
    socket_pkg::instr_t     instr_q;
    logic                   launch;
    logic                   irsp_hit;
    logic                   drsp_hit;

    assign launch = dcr_valid && (dcr_req.addr == `DCR_LAUNCH) && dcr_req.data[CORE_ID];

    // Responses are broadcast, keep only our own
    assign irsp_hit = icache_rsp_valid && (icache_rsp.tag == 2'(CORE_ID));
    assign drsp_hit = dcache_rsp_valid && (dcache_rsp.tag == 2'(CORE_ID));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            start_pc <= '0;
        end else begin
            if (dcr_valid && (dcr_req.addr == PC_REG[`DCR_ADDR_WIDTH-1:0])) begin
                start_pc <= dcr_req.data[`ADDR_WIDTH-1:0];
            end
            case (state)
                ST_IDLE:  if (launch) state <= ST_FETCH;
                ST_FETCH: if (icache_req_ready) state <= ST_IWAIT;
                ST_IWAIT: if (irsp_hit) state <= ST_EXEC;
                ST_EXEC: begin
                    case (instr_q.mem_fmt.op)
                        socket_pkg::OP_LOAD,
                        socket_pkg::OP_STORE: state <= ST_MEM;
                        socket_pkg::OP_ADD:   state <= ST_FETCH;
                        default:              state <= ST_IDLE;
                    endcase
                end
                ST_MEM:   if (dcache_req_ready) state <= ST_DWAIT;
                ST_DWAIT: if (drsp_hit) state <= ST_FETCH;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////
    // Datapath

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && launch) begin
            pc <= start_pc;
        end
        if (state == ST_IWAIT && irsp_hit) begin
            instr_q <= icache_rsp.data;
        end
        if (state == ST_EXEC && instr_q.alu_fmt.op == socket_pkg::OP_ADD) begin
            acc <= acc + {{(`DATA_WIDTH - 16){instr_q.alu_fmt.imm[15]}}, instr_q.alu_fmt.imm};
            pc  <= pc + 1'b1;
        end
        if (state == ST_DWAIT && drsp_hit) begin
            // Store ack carries no data
            if (instr_q.mem_fmt.op == socket_pkg::OP_LOAD) begin
                acc <= dcache_rsp.data;
            end
            pc <= pc + 1'b1;
        end
    end

    assign icache_req_valid = (state == ST_FETCH);
    assign icache_req.rw    = 1'b0;
    assign icache_req.addr  = pc;
    assign icache_req.data  = '0;
    assign icache_req.tag   = 2'(CORE_ID);

    assign dcache_req_valid = (state == ST_MEM);
    assign dcache_req.rw    = (instr_q.mem_fmt.op == socket_pkg::OP_STORE);
    assign dcache_req.addr  = instr_q.mem_fmt.addr;
    assign dcache_req.data  = acc;
    assign dcache_req.tag   = 2'(CORE_ID);

    assign busy = (state != ST_IDLE);

    a_no_launch_busy : assert property (@(posedge clk) disable iff (!rst_n)
        launch |-> !busy)
        else $error("socket_core %0d: launch while busy", CORE_ID);

endmodule

`default_nettype wire

// ==== src/mem_arb.sv ====
/*
 * Memory arbiter for the two L1 caches
 * Fixed priority to the icache, zero latency, responses routed by tag
 */
`timescale 1ns/1ps
`default_nettype none

module mem_arb (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 icache_req_valid,
    input  socket_pkg::mem_req_t icache_req,
    output logic                 icache_req_ready,
    input  logic                 dcache_req_valid,
    input  socket_pkg::mem_req_t dcache_req,
    output logic                 dcache_req_ready,
    output logic                 mem_req_valid,
    output socket_pkg::mem_req_t mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  socket_pkg::mem_rsp_t mem_rsp,
    output logic                 icache_rsp_valid,
    output socket_pkg::mem_rsp_t icache_rsp,
    output logic                 dcache_rsp_valid,
    output socket_pkg::mem_rsp_t dcache_rsp
);

    logic       grant_dcache;
    logic [2:0] rd_outstanding;

    // Icache wins whenever it asks
    assign grant_dcache     = dcache_req_valid && !icache_req_valid;
    assign icache_req_ready = mem_req_ready && !grant_dcache;
    assign dcache_req_ready = mem_req_ready && grant_dcache;
    assign mem_req_valid    = icache_req_valid || dcache_req_valid;

    // Tag is {core index, source}, icache is source 0
    always_comb begin
        mem_req     = grant_dcache ? dcache_req : icache_req;
        mem_req.tag = {mem_req.tag[0], grant_dcache};
    end

    assign icache_rsp_valid = mem_rsp_valid && !mem_rsp.tag[0];
    assign dcache_rsp_valid = mem_rsp_valid && mem_rsp.tag[0];
    assign icache_rsp.data  = mem_rsp.data;
    assign icache_rsp.tag   = {1'b0, mem_rsp.tag[1]};
    assign dcache_rsp.data  = mem_rsp.data;
    assign dcache_rsp.tag   = {1'b0, mem_rsp.tag[1]};

    ////////////////////
    // Read tracking

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_outstanding <= '0;
        end else begin
            rd_outstanding <= rd_outstanding
                + 3'((mem_req_valid && mem_req_ready && !mem_req.rw) ? 1 : 0)
                - 3'(mem_rsp_valid ? 1 : 0);
        end
    end

    a_rsp_has_read : assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> (rd_outstanding != 3'd0))
        else $error("mem_arb: response with no outstanding read");

endmodule

`default_nettype wire

// ==== src/l1_cache.sv ====
/*
 * L1 cache shared by all cores of the socket
 * Blocking, direct-mapped, one word per line, round-robin core pick,
 * write-through without allocation when WRITE_ENABLE is set
 */
`timescale 1ns/1ps
`default_nettype none
`include "socket_cfg.svh"

module l1_cache #(
    parameter bit WRITE_ENABLE = 1'b1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`SOCKET_SIZE-1:0]       core_req_valid,
    input  socket_pkg::mem_req_t          core_req [`SOCKET_SIZE],
    output logic [`SOCKET_SIZE-1:0]       core_req_ready,
    output logic [`SOCKET_SIZE-1:0]       core_rsp_valid,
    output socket_pkg::mem_rsp_t          core_rsp,
    output logic                          mem_req_valid,
    output socket_pkg::mem_req_t          mem_req,
    input  logic                          mem_req_ready,
    input  logic                          mem_rsp_valid,
    input  socket_pkg::mem_rsp_t          mem_rsp
);

    localparam int CORE_W = (`SOCKET_SIZE > 1) ? $clog2(`SOCKET_SIZE) : 1;
    localparam int IDX_W  = $clog2(`CACHE_LINES);
    localparam int TAG_W  = `ADDR_WIDTH - IDX_W;

    typedef enum logic [1:0] {
        ST_IDLE, ST_MISS_WAIT, ST_WRITE_WAIT, ST_RESPOND
    } state_e;

    state_e                  state;
    logic [CORE_W-1:0]       rr_ptr;
    logic [CORE_W-1:0]       sel_idx;
    logic                    sel_found;
    socket_pkg::mem_req_t    sel_req;
    socket_pkg::mem_req_t    req_q;
    logic [CORE_W-1:0]       req_core_q;
    logic                    mem_sent;
    logic                    rsp_valid_q;
    logic [`DATA_WIDTH-1:0]  rsp_data_q;

    logic [`CACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]        tag_q  [`CACHE_LINES];
    logic [`DATA_WIDTH-1:0]  data_q [`CACHE_LINES];

    logic [IDX_W-1:0]        sel_line;
    logic [IDX_W-1:0]        req_line;
    logic                    accept;
    logic                    is_write;
    logic                    hit;
    logic                    fill;

    ////////////////////
    // Core selection

    // Scan starts at the core after the last one served
    always_comb begin
        int cand;
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < `SOCKET_SIZE; i++) begin
            cand = (int'(rr_ptr) + i) % `SOCKET_SIZE;
            if (!sel_found && core_req_valid[cand]) begin
                sel_found = 1'b1;
                sel_idx   = CORE_W'(cand);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SOCKET_SIZE; i++) begin
            core_req_ready[i] = (state == ST_IDLE) && sel_found && (sel_idx == CORE_W'(i));
            core_rsp_valid[i] = rsp_valid_q && (req_core_q == CORE_W'(i));
        end
    end

    assign sel_req  = core_req[sel_idx];
    assign sel_line = sel_req.addr[IDX_W-1:0];
    assign req_line = req_q.addr[IDX_W-1:0];
    assign accept   = (state == ST_IDLE) && sel_found;
    assign is_write = WRITE_ENABLE && sel_req.rw;
    assign hit      = valid_q[sel_line] && (tag_q[sel_line] == sel_req.addr[`ADDR_WIDTH-1:IDX_W]);
    assign fill     = (state == ST_MISS_WAIT) && mem_rsp_valid;

    ////////////////////
    // Control FSM

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            rr_ptr      <= '0;
            mem_sent    <= 1'b0;
            rsp_valid_q <= 1'b0;
            valid_q     <= '0;
        end else begin
            rsp_valid_q <= 1'b0;
            if (mem_req_valid && mem_req_ready) begin
                mem_sent <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        rr_ptr   <= (sel_idx == CORE_W'(`SOCKET_SIZE - 1)) ? '0 : sel_idx + 1'b1;
                        mem_sent <= 1'b0;
                        if (is_write) begin
                            state <= ST_WRITE_WAIT;
                        end else if (hit) begin
                            rsp_valid_q <= 1'b1;
                        end else begin
                            state <= ST_MISS_WAIT;
                        end
                    end
                end
                ST_MISS_WAIT: begin
                    if (fill) begin
                        valid_q[req_line] <= 1'b1;
                        rsp_valid_q       <= 1'b1;
                        state             <= ST_RESPOND;
                    end
                end
                ST_WRITE_WAIT: begin
                    // Ack as soon as the write is on its way to memory
                    if (mem_req_valid && mem_req_ready) begin
                        rsp_valid_q <= 1'b1;
                        state       <= ST_RESPOND;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////
    // Arrays and payload

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q      <= sel_req;
            req_core_q <= sel_idx;
            if (!is_write && hit) begin
                rsp_data_q <= data_q[sel_line];
            end
            if (is_write && hit) begin
                data_q[sel_line] <= sel_req.data;
            end
        end
        if (fill) begin
            tag_q[req_line]  <= req_q.addr[`ADDR_WIDTH-1:IDX_W];
            data_q[req_line] <= mem_rsp.data;
            rsp_data_q       <= mem_rsp.data;
        end
    end

    assign core_rsp.data = rsp_data_q;
    assign core_rsp.tag  = 2'(req_core_q);

    // Memory side tag carries the requesting core
    assign mem_req_valid = ((state == ST_MISS_WAIT) || (state == ST_WRITE_WAIT)) && !mem_sent;
    always_comb begin
        mem_req     = req_q;
        mem_req.rw  = (state == ST_WRITE_WAIT);
        mem_req.tag = 2'(req_core_q);
    end

    a_rsp_only_in_miss : assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> (state == ST_MISS_WAIT))
        else $error("l1_cache: memory response outside miss-wait");

    a_read_only : assert property (@(posedge clk) disable iff (!rst_n)
        (!WRITE_ENABLE && accept) |-> !sel_req.rw)
        else $error("l1_cache: write request on read-only cache");

endmodule

`default_nettype wire

// ==== src/socket_pkg.sv ====
/*
 * Socket types
 * Memory request/response, DCR write and instruction formats
 */
`default_nettype none
`include "socket_cfg.svh"

package socket_pkg;

    typedef struct packed {
        logic                   rw;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
        logic [1:0]             tag;
    } mem_req_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data;
        logic [1:0]             tag;
    } mem_rsp_t;

    typedef struct packed {
        logic [`DCR_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]     data;
    } dcr_req_t;

    typedef enum logic [3:0] {
        OP_HALT  = 4'd0,
        OP_LOAD  = 4'd1,
        OP_ADD   = 4'd2,
        OP_STORE = 4'd3
    } opcode_t;

    // Load/store carry an address, ADD an immediate, in the same bits
    typedef union packed {
        struct packed {
            opcode_t     op;
            logic [11:0] spare;
            logic [15:0] addr;
        } mem_fmt;
        struct packed {
            opcode_t     op;
            logic [11:0] spare;
            logic [15:0] imm;
        } alu_fmt;
    } instr_t;

endpackage

`default_nettype wire

// ==== include/socket_cfg.svh ====
/*
 * Socket configuration
 * Core count, bus widths, cache depth and DCR register map
 */
`ifndef SOCKET_CFG_SVH
`define SOCKET_CFG_SVH

// Socket shape
`define SOCKET_SIZE       2
`define ADDR_WIDTH        16
`define DATA_WIDTH        32
`define CACHE_LINES       16

// DCR register map
`define DCR_ADDR_WIDTH    8
`define DCR_START_PC_BASE 8'h10
`define DCR_LAUNCH        8'h01

`endif
